/* logic/thrd_pkg.sv */
`default_nettype none

package thrd_pkg;

  // thread start address width
  localparam int ADDR_W = 16;
  // thread context data width
  localparam int DATA_W = 16;
  // active table capacity
  localparam int THREAD_SLOTS = 8;
  // table index and counter widths follow the capacity
  localparam int SLOT_W = $clog2(THREAD_SLOTS);
  localparam int COUNT_W = SLOT_W + 1;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] tdata_t;
  // data in the upper half, address in the lower half
  typedef logic [DATA_W+ADDR_W-1:0] entry_t;
  typedef logic [SLOT_W-1:0] slot_t;
  // 0 up to THREAD_SLOTS inclusive
  typedef logic [COUNT_W-1:0] count_t;

  // one-cycle command codes
  typedef enum logic [1:0] {
    CMD_NONE = 2'd0,
    CMD_RUN  = 2'd1,
    CMD_STOP = 2'd2
  } thrd_cmd_e;

  // scheduler sequencing
  typedef enum logic [2:0] {
    S_IDLE,
    // pending thread written into the table
    S_APPEND,
    // table read at the cursor in flight
    S_READ,
    // compare against the stop slot
    S_DECIDE,
    // replacement entry read in flight
    S_MOVE_READ,
    S_MOVE_WRITE,
    // next_valid_o pulse
    S_ISSUE
  } sched_state_e;

endpackage

`default_nettype wire

/* logic/slot_cursor.sv */
`timescale 1ns/10ps
`default_nettype none

module slot_cursor (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            cnt_inc_i,
  input  wire logic            cnt_dec_i,
  input  wire logic            cur_advance_i,
  input  wire logic            cur_set_i,
  input  wire thrd_pkg::slot_t cur_value_i,
  output thrd_pkg::slot_t      cursor_o,
  output thrd_pkg::count_t     count_o
);

  // cursor plus one, widened to compare with the count
  thrd_pkg::count_t cur_p1;
  // capacity in counter width
  thrd_pkg::count_t cnt_max;

  assign cur_p1 = thrd_pkg::count_t'(cursor_o) + thrd_pkg::count_t'(1);
  assign cnt_max = thrd_pkg::count_t'(thrd_pkg::THREAD_SLOTS);

  always_ff @(posedge clk) begin
    if (rst) begin
      cursor_o <= '0;
      count_o <= '0;
    end else begin
      // explicit load wins over advance
      if (cur_set_i) begin
        cursor_o <= cur_value_i;
      end else if (cur_advance_i) begin
        // round robin, wrap at the active count
        if (cur_p1 >= count_o) begin
          cursor_o <= '0;
        end else begin
          cursor_o <= cur_p1[thrd_pkg::SLOT_W-1:0];
        end
      end
      // count saturates at both ends
      if (cnt_inc_i && (count_o < cnt_max)) begin
        count_o <= count_o + thrd_pkg::count_t'(1);
      end else if (cnt_dec_i && (count_o != '0)) begin
        count_o <= count_o - thrd_pkg::count_t'(1);
      end
    end
  end

  // never more threads than table slots
  a_count_range: assert property (
    @(posedge clk) disable iff (rst)
    count_o <= cnt_max
  ) else $error("active count above table capacity");

  // cursor always points at a live entry
  a_cursor_range: assert property (
    @(posedge clk) disable iff (rst)
    (count_o != '0) |-> (thrd_pkg::count_t'(cursor_o) < count_o)
  ) else $error("cursor outside the active range");

endmodule

`default_nettype wire

/* logic/thread_table.sv */
`timescale 1ns/10ps
`default_nettype none

module thread_table (
  input  wire logic             clk,
  input  wire logic             wr_en_i,
  input  wire thrd_pkg::slot_t  rd_slot_i,
  input  wire thrd_pkg::slot_t  wr_slot_i,
  input  wire thrd_pkg::entry_t wr_entry_i,
  output thrd_pkg::entry_t      rd_entry_o
);

  // active threads, packed from slot 0 upward
  // entries past the active count are stale
  thrd_pkg::entry_t mem [thrd_pkg::THREAD_SLOTS];

  // single write port
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_slot_i] <= wr_entry_i;
    end
  end

  // registered read, data one cycle after the index
  // a same-cycle write to that slot returns the old entry
  always_ff @(posedge clk) begin
    rd_entry_o <= mem[rd_slot_i];
  end

endmodule

`default_nettype wire

/* logic/request_slots.sv */
`timescale 1ns/10ps
`default_nettype none

module request_slots (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                pend_take_i,
  input  wire logic                stop_clear_i,
  input  wire thrd_pkg::thrd_cmd_e cmd_i,
  input  wire thrd_pkg::addr_t     cmd_addr_i,
  input  wire thrd_pkg::tdata_t    cmd_data_i,
  input  wire thrd_pkg::slot_t     cursor_i,
  input  wire thrd_pkg::count_t    count_i,
  output logic                     pend_full_o,
  output logic                     stop_armed_o,
  output logic                     cmd_done_o,
  output logic                     cmd_ok_o,
  output thrd_pkg::entry_t         pend_entry_o,
  output thrd_pkg::entry_t         stop_entry_o,
  output thrd_pkg::slot_t          stop_mark_o
);

  logic run_ok;
  logic stop_ok;
  // count once the pending thread lands in the table
  thrd_pkg::count_t count_p1;

  assign count_p1 = count_i + thrd_pkg::count_t'(1);

  // run needs a free pending slot and room in the table
  assign run_ok = !pend_full_o
               && (count_p1 <= thrd_pkg::count_t'(thrd_pkg::THREAD_SLOTS));
  // only one stop outstanding at a time
  assign stop_ok = !stop_armed_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      // boot thread at address 0, data 0 waits in the pending slot
      pend_full_o <= 1'b1;
      pend_entry_o <= '0;
      stop_armed_o <= 1'b0;
      cmd_done_o <= 1'b0;
      cmd_ok_o <= 1'b0;
    end else begin
      // reply one cycle after every command
      cmd_done_o <= (cmd_i != thrd_pkg::CMD_NONE);
      cmd_ok_o <= 1'b0;
      // scheduler consumed the pending thread
      if (pend_take_i) begin
        pend_full_o <= 1'b0;
      end
      // stop done or expired
      if (stop_clear_i) begin
        stop_armed_o <= 1'b0;
      end
      case (cmd_i)
        thrd_pkg::CMD_RUN: begin
          if (run_ok) begin
            pend_full_o <= 1'b1;
            pend_entry_o <= {cmd_data_i, cmd_addr_i};
            cmd_ok_o <= 1'b1;
          end
        end
        thrd_pkg::CMD_STOP: begin
          if (stop_ok) begin
            stop_armed_o <= 1'b1;
            cmd_ok_o <= 1'b1;
          end
        end
        default: begin
          cmd_ok_o <= 1'b0;
        end
      endcase
    end
  end

  // stop target and the cursor position at arming
  // mark lets the scheduler expire the stop after a full pass
  always_ff @(posedge clk) begin
    if ((cmd_i == thrd_pkg::CMD_STOP) && stop_ok) begin
      stop_entry_o <= {cmd_data_i, cmd_addr_i};
      stop_mark_o <= cursor_i;
    end
  end

  // every command gets its reply
  a_cmd_reply: assert property (
    @(posedge clk) disable iff (rst)
    (cmd_i != thrd_pkg::CMD_NONE) |=> cmd_done_o
  ) else $error("command without cmd_done_o");

endmodule

`default_nettype wire

/* logic/thread_sched_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module thread_sched_fsm (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             next_i,
  input  wire logic             pend_full_i,
  input  wire logic             stop_armed_i,
  input  wire thrd_pkg::entry_t pend_entry_i,
  input  wire thrd_pkg::entry_t stop_entry_i,
  input  wire thrd_pkg::entry_t rd_entry_i,
  input  wire thrd_pkg::slot_t  stop_mark_i,
  input  wire thrd_pkg::slot_t  cursor_i,
  input  wire thrd_pkg::count_t count_i,
  output logic                  pend_take_o,
  output logic                  stop_clear_o,
  output logic                  cnt_inc_o,
  output logic                  cnt_dec_o,
  output logic                  cur_advance_o,
  output logic                  cur_set_o,
  output logic                  wr_en_o,
  output logic                  next_valid_o,
  output logic                  busy_o,
  output thrd_pkg::slot_t       cur_value_o,
  output thrd_pkg::slot_t       rd_slot_o,
  output thrd_pkg::slot_t       wr_slot_o,
  output thrd_pkg::entry_t      wr_entry_o,
  output thrd_pkg::entry_t      issue_entry_o
);

  thrd_pkg::sched_state_e state_q;
  thrd_pkg::sched_state_e state_d;
  // one request remembered while busy
  logic req_q;
  // removal rewrites the cursor slot
  logic move_q;
  thrd_pkg::slot_t rd_slot_q;
  // slot receiving the moved entry
  thrd_pkg::slot_t move_slot_q;
  // last issued thread
  thrd_pkg::entry_t issue_q;

  logic serve;
  logic hit;
  logic remove;
  logic last_slot;
  thrd_pkg::count_t cnt_m1;
  thrd_pkg::count_t cur_p1;
  thrd_pkg::slot_t cur_wrap;

  assign serve = next_i || req_q;
  assign cnt_m1 = count_i - thrd_pkg::count_t'(1);
  assign cur_p1 = thrd_pkg::count_t'(cursor_i) + thrd_pkg::count_t'(1);
  // cursor after a plain round-robin step
  assign cur_wrap = (cur_p1 >= count_i) ? '0 : cur_p1[thrd_pkg::SLOT_W-1:0];
  // entry read at the cursor is the one to stop
  assign hit = stop_armed_i && (rd_entry_i == stop_entry_i);
  // a sole thread is never removed
  assign remove = hit && (count_i > thrd_pkg::count_t'(1));
  assign last_slot = (thrd_pkg::count_t'(cursor_i) == cnt_m1);

  always_comb begin
    state_d = state_q;
    stop_clear_o = 1'b0;
    cnt_dec_o = 1'b0;
    cur_advance_o = 1'b0;
    cur_set_o = 1'b0;
    cur_value_o = '0;
    case (state_q)
      thrd_pkg::S_IDLE: begin
        // pending thread first, else the table, else drop
        if (serve && pend_full_i) begin
          state_d = thrd_pkg::S_APPEND;
        end else if (serve && (count_i != '0)) begin
          state_d = thrd_pkg::S_READ;
        end
      end
      thrd_pkg::S_APPEND: state_d = thrd_pkg::S_ISSUE;
      thrd_pkg::S_READ: state_d = thrd_pkg::S_DECIDE;
      thrd_pkg::S_DECIDE: begin
        if (remove) begin
          cnt_dec_o = 1'b1;
          cur_set_o = 1'b1;
          stop_clear_o = 1'b1;
          state_d = thrd_pkg::S_MOVE_READ;
          // slot 0 goes out, cursor to 1 modulo the new count
          if (last_slot) begin
            cur_value_o = (cnt_m1 == thrd_pkg::count_t'(1)) ? '0 : thrd_pkg::slot_t'(1);
          // moved entry goes out, cursor steps past it
          end else if (cur_p1 == cnt_m1) begin
            cur_value_o = '0;
          end else begin
            cur_value_o = cur_p1[thrd_pkg::SLOT_W-1:0];
          end
        end else begin
          cur_advance_o = 1'b1;
          state_d = thrd_pkg::S_ISSUE;
          // sole matching thread, or a full pass back to the mark
          if (hit || (stop_armed_i && (cur_wrap == stop_mark_i))) begin
            stop_clear_o = 1'b1;
          end
        end
      end
      thrd_pkg::S_MOVE_READ: state_d = thrd_pkg::S_MOVE_WRITE;
      thrd_pkg::S_MOVE_WRITE: state_d = thrd_pkg::S_ISSUE;
      thrd_pkg::S_ISSUE: state_d = thrd_pkg::S_IDLE;
      default: state_d = thrd_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= thrd_pkg::S_IDLE;
      req_q <= 1'b0;
      move_q <= 1'b0;
      rd_slot_q <= '0;
      move_slot_q <= '0;
    end else begin
      state_q <= state_d;
      // idle serves the remembered one, a fresh pulse stays stored
      if (state_q == thrd_pkg::S_IDLE) begin
        req_q <= req_q && next_i;
      end else if (next_i) begin
        req_q <= 1'b1;
      end
      if ((state_q == thrd_pkg::S_IDLE) && serve) begin
        rd_slot_q <= cursor_i;
      end
      // fetch slot 0 or the last entry for the removal
      if ((state_q == thrd_pkg::S_DECIDE) && remove) begin
        rd_slot_q <= last_slot ? '0 : cnt_m1[thrd_pkg::SLOT_W-1:0];
        move_slot_q <= cursor_i;
        move_q <= !last_slot;
      end
    end
  end

  // issued thread held until the next issue
  always_ff @(posedge clk) begin
    if (state_q == thrd_pkg::S_APPEND) begin
      issue_q <= pend_entry_i;
    end else if ((state_q == thrd_pkg::S_DECIDE) && !remove) begin
      issue_q <= rd_entry_i;
    end else if (state_q == thrd_pkg::S_MOVE_WRITE) begin
      issue_q <= rd_entry_i;
    end
  end

  assign pend_take_o = (state_q == thrd_pkg::S_APPEND);
  assign cnt_inc_o = (state_q == thrd_pkg::S_APPEND);
  assign wr_en_o = (state_q == thrd_pkg::S_APPEND)
                || ((state_q == thrd_pkg::S_MOVE_WRITE) && move_q);
  // append lands just past the last active entry
  assign wr_slot_o = (state_q == thrd_pkg::S_APPEND) ? count_i[thrd_pkg::SLOT_W-1:0]
                                                     : move_slot_q;
  assign wr_entry_o = (state_q == thrd_pkg::S_APPEND) ? pend_entry_i : rd_entry_i;
  assign rd_slot_o = rd_slot_q;
  assign issue_entry_o = issue_q;
  assign next_valid_o = (state_q == thrd_pkg::S_ISSUE);
  assign busy_o = (state_q != thrd_pkg::S_IDLE);

  // issue is a single-cycle pulse
  a_valid_pulse: assert property (
    @(posedge clk) disable iff (rst)
    next_valid_o |=> !next_valid_o
  ) else $error("next_valid_o held two cycles");

  // append never lands past the table, relies on the run test upstream
  a_append_room: assert property (
    @(posedge clk) disable iff (rst)
    pend_take_o |-> (count_i < thrd_pkg::count_t'(thrd_pkg::THREAD_SLOTS))
  ) else $error("append into a full table");

endmodule

`default_nettype wire

/* logic/thread_manager.sv */
`timescale 1ns/10ps
`default_nettype none

module thread_manager (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                next_i,
  input  wire thrd_pkg::thrd_cmd_e cmd_i,
  input  wire thrd_pkg::addr_t     cmd_addr_i,
  input  wire thrd_pkg::tdata_t    cmd_data_i,
  output wire logic                cmd_done_o,
  output wire logic                cmd_ok_o,
  output wire logic                next_valid_o,
  output wire thrd_pkg::addr_t     next_addr_o,
  output wire thrd_pkg::tdata_t    next_data_o,
  output wire logic                busy_o
);

  // slots to scheduler
  logic pend_full;
  logic stop_armed;
  thrd_pkg::entry_t pend_entry;
  thrd_pkg::entry_t stop_entry;
  thrd_pkg::slot_t stop_mark;
  // scheduler to slots
  logic pend_take;
  logic stop_clear;
  // cursor and count
  thrd_pkg::slot_t cursor;
  thrd_pkg::count_t count;
  logic cnt_inc;
  logic cnt_dec;
  logic cur_advance;
  logic cur_set;
  thrd_pkg::slot_t cur_value;
  // table ports
  thrd_pkg::slot_t rd_slot;
  thrd_pkg::entry_t rd_entry;
  logic wr_en;
  thrd_pkg::slot_t wr_slot;
  thrd_pkg::entry_t wr_entry;
  thrd_pkg::entry_t issue_entry;

  thread_sched_fsm i_fsm (
    .clk           (clk),
    .rst           (rst),
    .next_i        (next_i),
    .pend_full_i   (pend_full),
    .stop_armed_i  (stop_armed),
    .pend_entry_i  (pend_entry),
    .stop_entry_i  (stop_entry),
    .rd_entry_i    (rd_entry),
    .stop_mark_i   (stop_mark),
    .cursor_i      (cursor),
    .count_i       (count),
    .pend_take_o   (pend_take),
    .stop_clear_o  (stop_clear),
    .cnt_inc_o     (cnt_inc),
    .cnt_dec_o     (cnt_dec),
    .cur_advance_o (cur_advance),
    .cur_set_o     (cur_set),
    .wr_en_o       (wr_en),
    .next_valid_o  (next_valid_o),
    .busy_o        (busy_o),
    .cur_value_o   (cur_value),
    .rd_slot_o     (rd_slot),
    .wr_slot_o     (wr_slot),
    .wr_entry_o    (wr_entry),
    .issue_entry_o (issue_entry)
  );

  slot_cursor i_cursor (
    .clk           (clk),
    .rst           (rst),
    .cnt_inc_i     (cnt_inc),
    .cnt_dec_i     (cnt_dec),
    .cur_advance_i (cur_advance),
    .cur_set_i     (cur_set),
    .cur_value_i   (cur_value),
    .cursor_o      (cursor),
    .count_o       (count)
  );

  thread_table i_table (
    .clk        (clk),
    .wr_en_i    (wr_en),
    .rd_slot_i  (rd_slot),
    .wr_slot_i  (wr_slot),
    .wr_entry_i (wr_entry),
    .rd_entry_o (rd_entry)
  );

  request_slots i_slots (
    .clk          (clk),
    .rst          (rst),
    .pend_take_i  (pend_take),
    .stop_clear_i (stop_clear),
    .cmd_i        (cmd_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_data_i   (cmd_data_i),
    .cursor_i     (cursor),
    .count_i      (count),
    .pend_full_o  (pend_full),
    .stop_armed_o (stop_armed),
    .cmd_done_o   (cmd_done_o),
    .cmd_ok_o     (cmd_ok_o),
    .pend_entry_o (pend_entry),
    .stop_entry_o (stop_entry),
    .stop_mark_o  (stop_mark)
  );

  // split the issued entry, address low, data high
  assign next_addr_o = issue_entry[thrd_pkg::ADDR_W-1:0];
  assign next_data_o = issue_entry[thrd_pkg::ADDR_W +: thrd_pkg::DATA_W];

endmodule

`default_nettype wire

/* sim/thread_manager_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module thread_manager_tb;

  // step codes, first column of the stimulus file
  localparam logic [3:0] OP_RUN = 4'h1;
  localparam logic [3:0] OP_STOP = 4'h2;
  localparam logic [3:0] OP_NEXT = 4'h3;
  localparam int MAX_STEPS = 128;
  // cycles allowed from next_i to next_valid_o
  localparam int NEXT_LIMIT = 16;
  // watchdog budget per step
  localparam int STEP_NS = 200;

  logic clk;
  logic rst;
  logic next_i;
  thrd_pkg::thrd_cmd_e cmd_i;
  thrd_pkg::addr_t cmd_addr_i;
  thrd_pkg::tdata_t cmd_data_i;
  logic cmd_done_o;
  logic cmd_ok_o;
  logic next_valid_o;
  thrd_pkg::addr_t next_addr_o;
  thrd_pkg::tdata_t next_data_o;
  logic busy_o;

  // one word per step holds op, addr, data and expected accept
  logic [39:0] steps [MAX_STEPS];
  int num_steps;
  logic steps_loaded;
  int num_pass;
  int num_fail;

  thread_manager i_thread_manager (
    .clk          (clk),
    .rst          (rst),
    .next_i       (next_i),
    .cmd_i        (cmd_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_done_o   (cmd_done_o),
    .cmd_ok_o     (cmd_ok_o),
    .next_valid_o (next_valid_o),
    .next_addr_o  (next_addr_o),
    .next_data_o  (next_data_o),
    .busy_o       (busy_o)
  );

  // 20 ns clock
  initial clk = 1'b0;
  always #10 clk = ~clk;

  // all replies idle right after reset
  task automatic check_reset_outputs();
    if ({next_valid_o, cmd_done_o, cmd_ok_o, busy_o} !== 4'b0000) begin
      $display("CHECK FAILED reset outputs expected valid/done/ok/busy 0000 actual %b",
               {next_valid_o, cmd_done_o, cmd_ok_o, busy_o});
      num_fail++;
    end else begin
      $display("ok reset outputs");
      num_pass++;
    end
  endtask

  // one-cycle command with its reply checked a cycle later
  task automatic send_command(input string name, input thrd_pkg::thrd_cmd_e code,
                              input thrd_pkg::addr_t addr, input thrd_pkg::tdata_t data,
                              input logic exp_ok);
    @(posedge clk);
    #2;
    cmd_i = code;
    cmd_addr_i = addr;
    cmd_data_i = data;
    @(posedge clk);
    #2;
    cmd_i = thrd_pkg::CMD_NONE;
    if (cmd_done_o !== 1'b1) begin
      $display("CHECK FAILED %s expected done=1 actual done=%b", name, cmd_done_o);
      num_fail++;
    end else if (cmd_ok_o !== exp_ok) begin
      $display("CHECK FAILED %s expected ok=%0b actual ok=%0b", name, exp_ok, cmd_ok_o);
      num_fail++;
    end else begin
      $display("ok %s accept=%0b", name, cmd_ok_o);
      num_pass++;
    end
  endtask

  // pulse next_i, then wait for the issue pulse
  task automatic request_next(input string name, input thrd_pkg::addr_t exp_addr,
                              input thrd_pkg::tdata_t exp_data);
    int waited;
    logic busy_low;
    waited = 0;
    busy_low = 1'b0;
    @(posedge clk);
    #2;
    next_i = 1'b1;
    @(posedge clk);
    #2;
    next_i = 1'b0;
    // busy from the cycle after next_i up to the issue cycle
    if (busy_o !== 1'b1) begin
      busy_low = 1'b1;
    end
    while (!next_valid_o && (waited < NEXT_LIMIT)) begin
      @(posedge clk);
      #2;
      waited++;
      if (busy_o !== 1'b1) begin
        busy_low = 1'b1;
      end
    end
    if (!next_valid_o) begin
      $display("%s: no next_valid_o within %0d cycles", name, NEXT_LIMIT);
      num_fail++;
    end else if (busy_low) begin
      $display("CHECK FAILED %s expected busy=1 actual busy=0 before the issue", name);
      num_fail++;
    end else if ((next_addr_o !== exp_addr) || (next_data_o !== exp_data)) begin
      $display("CHECK FAILED %s expected %h/%h actual %h/%h",
               name, exp_addr, exp_data, next_addr_o, next_data_o);
      num_fail++;
    end else begin
      $display("ok %s issued %h/%h", name, next_addr_o, next_data_o);
      num_pass++;
    end
  endtask

  initial begin
    int idx;
    logic [3:0] op;
    thrd_pkg::addr_t addr;
    thrd_pkg::tdata_t data;
    logic exp_ok;
    rst = 1'b1;
    next_i = 1'b0;
    cmd_i = thrd_pkg::CMD_NONE;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    num_pass = 0;
    num_fail = 0;
    steps_loaded = 1'b0;
    $readmemh("sim/stimulus_thread_manager.txt", steps);
    // steps end at the first word not loaded or with op 0
    num_steps = 0;
    while ((num_steps < MAX_STEPS) && !$isunknown(steps[num_steps])
           && (steps[num_steps][39:36] != 4'h0)) begin
      num_steps++;
    end
    steps_loaded = 1'b1;
    if (num_steps == 0) begin
      $display("stimulus file holds no steps");
      num_fail++;
    end
    // reset for two cycles
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    check_reset_outputs();
    for (idx = 0; idx < num_steps; idx++) begin
      op = steps[idx][39:36];
      addr = steps[idx][35:20];
      data = steps[idx][19:4];
      exp_ok = steps[idx][0];
      case (op)
        OP_RUN: send_command($sformatf("step %0d run", idx), thrd_pkg::CMD_RUN,
                             addr, data, exp_ok);
        OP_STOP: send_command($sformatf("step %0d stop", idx), thrd_pkg::CMD_STOP,
                              addr, data, exp_ok);
        OP_NEXT: request_next($sformatf("step %0d next", idx), addr, data);
        default: begin
          $display("step %0d: unknown step code %h in the stimulus file", idx, op);
          num_fail++;
        end
      endcase
    end
    $display("%0d tests passed, %0d failed", num_pass, num_fail);
    if (num_fail == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // run limit scales with the step count
  initial begin
    wait (steps_loaded);
    #(num_steps * STEP_NS + 100);
    $display("watchdog expired after %0d ns, the run did not complete",
             num_steps * STEP_NS + 100);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/stimulus_thread_manager.txt */
// op_addr_data_ok, op 1 run, 2 stop, 3 next
// run and stop carry the expected accept, next carries the expected address and data
// boot thread first
3_0000_0000_0
// run accepted, second run refused while pending
1_1000_a001_1
1_1001_a0ff_0
3_1000_a001_0
1_2000_b002_1
3_2000_b002_0
// round robin over three threads with wrap
3_0000_0000_0
3_1000_a001_0
3_2000_b002_0
3_0000_0000_0
// fourth thread, then stop the middle one
1_3000_c003_1
3_3000_c003_0
2_2000_b002_1
2_1000_a001_0
3_1000_a001_0
// last thread moves into the stopped slot
3_3000_c003_0
3_0000_0000_0
3_1000_a001_0
3_3000_c003_0
// stop on an absent thread expires after one pass
2_9999_dead_1
2_8888_beef_0
3_0000_0000_0
3_1000_a001_0
3_3000_c003_0
2_7777_7777_1
// fill the table to eight threads
1_4000_c004_1
3_4000_c004_0
1_5000_c005_1
3_5000_c005_0
1_6000_c006_1
3_6000_c006_0
1_7000_c007_1
3_7000_c007_0
1_8000_c008_1
3_8000_c008_0
// ninth thread refused
1_9000_c009_0
3_0000_0000_0
3_1000_a001_0
3_3000_c003_0
3_4000_c004_0

/* src.f */
logic/thrd_pkg.sv
logic/slot_cursor.sv
logic/thread_table.sv
logic/request_slots.sv
logic/thread_sched_fsm.sv
logic/thread_manager.sv
sim/thread_manager_tb.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = thread_manager_tb
RTL_TOP    = thread_manager
FILELIST   = src.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
